//--- rtl/core_pkg.sv
// RV32I core shared definitions
package core_pkg;

	typedef logic [31:0] word_t;    // data word or byte address.
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  wb_sel_t;

	// alu operations.
	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_SLL    = 4'd2;
	localparam alu_op_t ALU_SLT    = 4'd3;
	localparam alu_op_t ALU_SLTU   = 4'd4;
	localparam alu_op_t ALU_XOR    = 4'd5;
	localparam alu_op_t ALU_SRL    = 4'd6;
	localparam alu_op_t ALU_SRA    = 4'd7;
	localparam alu_op_t ALU_OR     = 4'd8;
	localparam alu_op_t ALU_AND    = 4'd9;
	localparam alu_op_t ALU_PASS_B = 4'd10;  // lui passes the immediate.

	// register write-back source.
	localparam wb_sel_t WB_ALU = 2'd0;
	localparam wb_sel_t WB_MEM = 2'd1;
	localparam wb_sel_t WB_PC4 = 2'd2;

	// major opcodes, bits 6:0 of the instruction.
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OPIMM  = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;

	// one fetch, then one execute cycle per instruction.
	typedef enum logic [1:0] {
		FETCH_REQ,
		FETCH_WAIT,
		EXEC
	} fetch_state_t;

endpackage

//--- rtl/pcu.sv
// Program counter unit
module pcu #(
	parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            exec_en,
	input  logic            branch_taken,
	input  logic            is_jal,
	input  logic            is_jalr,
	input  core_pkg::word_t imm,
	input  core_pkg::word_t rs1_data,
	output core_pkg::word_t pc,
	output core_pkg::word_t next_pc
);

	import core_pkg::*;

	word_t pc_plus4;
	word_t rel_target;   // branch and jal target.
	word_t jalr_sum;

	assign pc_plus4   = pc + 32'd4;
	assign rel_target = pc + imm;
	assign jalr_sum   = rs1_data + imm;

	// next pc is valid whenever the decoded controls are.
	always_comb begin
		if (is_jalr) begin
			next_pc = {jalr_sum[31:1], 1'b0};  // bit 0 cleared.
		end else if (is_jal || branch_taken) begin
			next_pc = rel_target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	// pc moves only at the end of the execute cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (exec_en) begin
			pc <= next_pc;
		end
	end

endmodule

//--- rtl/ifu.sv
// Instruction fetch unit
module ifu (
	input  logic            clk,
	input  logic            rst,
	input  core_pkg::word_t pc,
	output logic            imem_req_valid,
	input  logic            imem_req_ready,
	output core_pkg::word_t imem_addr,
	input  logic            imem_rsp_valid,
	input  core_pkg::inst_t imem_rsp_data,
	output core_pkg::inst_t inst,
	output logic            exec_en
);

	import core_pkg::*;

	fetch_state_t state, state_next;
	logic         req_fire;

	assign req_fire  = imem_req_valid && imem_req_ready;
	assign imem_addr = pc;                 // pc only changes after exec.
	assign exec_en   = (state == EXEC);

	always_comb begin
		state_next = state;
		case (state)
			FETCH_REQ:  if (req_fire) state_next = FETCH_WAIT;
			FETCH_WAIT: if (imem_rsp_valid) state_next = EXEC;
			EXEC:       state_next = FETCH_REQ;
			default:    state_next = FETCH_REQ;
		endcase
	end

	// valid is registered so it stays low through reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			state          <= FETCH_REQ;
			imem_req_valid <= 1'b0;
		end else begin
			state          <= state_next;
			imem_req_valid <= (state_next == FETCH_REQ);
		end
	end

	// instruction register.
	always_ff @(posedge clk) begin
		if (state == FETCH_WAIT && imem_rsp_valid) begin
			inst <= imem_rsp_data;
		end
	end

endmodule

//--- rtl/idu.sv
// Instruction decode unit
module idu (
	input  core_pkg::inst_t    inst,
	output core_pkg::reg_idx_t rs1,
	output core_pkg::reg_idx_t rs2,
	output core_pkg::reg_idx_t rd,
	output core_pkg::word_t    imm,
	output core_pkg::alu_op_t  alu_op,
	output logic               alu_src_pc,
	output logic               alu_src_imm,
	output logic               rd_we,
	output logic               is_branch,
	output logic               is_jal,
	output logic               is_jalr,
	output logic               is_load,
	output logic               is_store,
	output core_pkg::wb_sel_t  wb_sel,
	output logic [2:0]         funct3
);

	import core_pkg::*;

	opcode_t opcode;
	word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
	alu_op_t arith_op;   // op and op-imm mapping.
	logic    writes_rd;

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// sub only exists in op, srai shares bit 30 with sra.
	always_comb begin
		case (funct3)
			3'b000:  arith_op = (opcode == OPC_OP && inst[30]) ? ALU_SUB : ALU_ADD;
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = inst[30] ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		// unknown opcodes fall through as a no-op.
		imm         = imm_i;
		alu_op      = ALU_ADD;
		alu_src_pc  = 1'b0;
		alu_src_imm = 1'b0;
		writes_rd   = 1'b0;
		is_branch   = 1'b0;
		is_jal      = 1'b0;
		is_jalr     = 1'b0;
		is_load     = 1'b0;
		is_store    = 1'b0;
		wb_sel      = WB_ALU;
		case (opcode)
			OPC_LUI: begin
				imm         = imm_u;
				alu_op      = ALU_PASS_B;
				alu_src_imm = 1'b1;
				writes_rd   = 1'b1;
			end
			OPC_AUIPC: begin
				imm         = imm_u;
				alu_src_pc  = 1'b1;
				alu_src_imm = 1'b1;
				writes_rd   = 1'b1;
			end
			OPC_JAL: begin
				imm       = imm_j;
				is_jal    = 1'b1;
				writes_rd = 1'b1;
				wb_sel    = WB_PC4;   // link value.
			end
			OPC_JALR: begin
				alu_src_imm = 1'b1;
				is_jalr     = 1'b1;
				writes_rd   = 1'b1;
				wb_sel      = WB_PC4;
			end
			OPC_BRANCH: begin
				imm       = imm_b;
				is_branch = 1'b1;
			end
			OPC_LOAD: begin
				alu_src_imm = 1'b1;   // address is rs1 + imm.
				is_load     = 1'b1;
				writes_rd   = 1'b1;
				wb_sel      = WB_MEM;
			end
			OPC_STORE: begin
				imm         = imm_s;
				alu_src_imm = 1'b1;
				is_store    = 1'b1;
			end
			OPC_OPIMM: begin
				alu_op      = arith_op;
				alu_src_imm = 1'b1;
				writes_rd   = 1'b1;
			end
			OPC_OP: begin
				alu_op    = arith_op;
				writes_rd = 1'b1;
			end
			default: ;
		endcase
	end

	assign rd_we = writes_rd && (rd != 5'd0);   // x0 writes never report.

endmodule

//--- rtl/gpr.sv
// General register file
module gpr (
	input  logic               clk,
	input  logic               rst,
	input  core_pkg::reg_idx_t rs1,
	input  core_pkg::reg_idx_t rs2,
	input  core_pkg::reg_idx_t rd,
	input  logic               we,
	input  core_pkg::word_t    wdata,
	output core_pkg::word_t    rs1_data,
	output core_pkg::word_t    rs2_data
);

	import core_pkg::*;

	word_t regs [1:31];   // x0 has no storage.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 reads as zero.
	assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- rtl/exu.sv
// Execute unit and branch compare
module exu (
	input  core_pkg::word_t   pc,
	input  core_pkg::word_t   rs1_data,
	input  core_pkg::word_t   rs2_data,
	input  core_pkg::word_t   imm,
	input  core_pkg::alu_op_t alu_op,
	input  logic              alu_src_pc,
	input  logic              alu_src_imm,
	input  logic              is_branch,
	input  logic [2:0]        funct3,
	output core_pkg::word_t   alu_result,
	output logic              branch_taken
);

	import core_pkg::*;

	word_t      op_a, op_b;
	logic [4:0] shamt;
	logic       eq, lt, ltu;
	logic       cond;

	assign op_a  = alu_src_pc  ? pc  : rs1_data;
	assign op_b  = alu_src_imm ? imm : rs2_data;
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD:    alu_result = op_a + op_b;
			ALU_SUB:    alu_result = op_a - op_b;
			ALU_SLL:    alu_result = op_a << shamt;
			ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
			ALU_XOR:    alu_result = op_a ^ op_b;
			ALU_SRL:    alu_result = op_a >> shamt;
			ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
			ALU_OR:     alu_result = op_a | op_b;
			ALU_AND:    alu_result = op_a & op_b;
			ALU_PASS_B: alu_result = op_b;
			default:    alu_result = op_a + op_b;
		endcase
	end

	// branches always compare the two registers.
	assign eq  = (rs1_data == rs2_data);
	assign lt  = $signed(rs1_data) < $signed(rs2_data);
	assign ltu = rs1_data < rs2_data;

	always_comb begin
		case (funct3)
			3'b000:  cond = eq;    // beq.
			3'b001:  cond = !eq;   // bne.
			3'b100:  cond = lt;
			3'b101:  cond = !lt;
			3'b110:  cond = ltu;
			3'b111:  cond = !ltu;
			default: cond = 1'b0;  // reserved encodings fall through.
		endcase
	end

	assign branch_taken = is_branch && cond;

endmodule

//--- rtl/lsu.sv
// Load/store unit with data memory
module lsu #(
	parameter int DMEM_WORDS = 64
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            exec_en,
	input  logic            is_load,
	input  logic            is_store,
	input  core_pkg::word_t addr,
	input  core_pkg::word_t wdata,
	output core_pkg::word_t rdata
);

	import core_pkg::*;

	localparam int IDX_W = $clog2(DMEM_WORDS);

	word_t            mem [DMEM_WORDS];
	logic [IDX_W-1:0] idx;

	// word index, upper address bits wrap around.
	assign idx = addr[IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (exec_en && is_store) begin
			mem[idx] <= wdata;   // store lands at the end of exec.
		end
	end

	// combinational read, zero when no load.
	assign rdata = is_load ? mem[idx] : '0;

endmodule

//--- rtl/top.sv
// RV32I core top
module top #(
	parameter core_pkg::word_t RESET_PC   = 32'h0000_0000,
	parameter int              DMEM_WORDS = 64
) (
	input  logic               clk,
	input  logic               rst,
	output logic               imem_req_valid,
	input  logic               imem_req_ready,
	output core_pkg::word_t    imem_addr,
	input  logic               imem_rsp_valid,
	input  core_pkg::inst_t    imem_rsp_data,
	output logic               retire_valid,
	output core_pkg::word_t    retire_pc,
	output core_pkg::word_t    retire_next_pc,
	output logic               retire_rd_we,
	output core_pkg::reg_idx_t retire_rd,
	output core_pkg::word_t    retire_data
);

	import core_pkg::*;

	word_t    pc, next_pc, imm, rs1_data, rs2_data, alu_result, mem_rdata, wb_data;
	inst_t    inst;
	reg_idx_t rs1, rs2, rd;
	alu_op_t  alu_op;
	wb_sel_t  wb_sel;
	logic     exec_en, branch_taken, alu_src_pc, alu_src_imm, rd_we;
	logic     is_branch, is_jal, is_jalr, is_load, is_store;
	logic [2:0] funct3;

	pcu #(.RESET_PC(RESET_PC)) u_pcu (
		.clk(clk), .rst(rst), .exec_en(exec_en), .branch_taken(branch_taken),
		.is_jal(is_jal), .is_jalr(is_jalr), .imm(imm), .rs1_data(rs1_data),
		.pc(pc), .next_pc(next_pc)
	);

	ifu u_ifu (
		.clk(clk), .rst(rst), .pc(pc),
		.imem_req_valid(imem_req_valid), .imem_req_ready(imem_req_ready),
		.imem_addr(imem_addr), .imem_rsp_valid(imem_rsp_valid),
		.imem_rsp_data(imem_rsp_data), .inst(inst), .exec_en(exec_en)
	);

	idu u_idu (
		.inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
		.alu_src_pc(alu_src_pc), .alu_src_imm(alu_src_imm), .rd_we(rd_we),
		.is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
		.is_load(is_load), .is_store(is_store), .wb_sel(wb_sel), .funct3(funct3)
	);

	gpr u_gpr (
		.clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
		.we(exec_en && rd_we),   // commit only in exec.
		.wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	exu u_exu (
		.pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
		.alu_op(alu_op), .alu_src_pc(alu_src_pc), .alu_src_imm(alu_src_imm),
		.is_branch(is_branch), .funct3(funct3),
		.alu_result(alu_result), .branch_taken(branch_taken)
	);

	lsu #(.DMEM_WORDS(DMEM_WORDS)) u_lsu (
		.clk(clk), .rst(rst), .exec_en(exec_en), .is_load(is_load),
		.is_store(is_store), .addr(alu_result), .wdata(rs2_data), .rdata(mem_rdata)
	);

	always_comb begin
		case (wb_sel)
			WB_MEM:  wb_data = mem_rdata;
			WB_PC4:  wb_data = pc + 32'd4;   // jal and jalr link.
			default: wb_data = alu_result;
		endcase
	end

	// one trace entry per exec cycle.
	assign retire_valid   = exec_en;
	assign retire_pc      = pc;
	assign retire_next_pc = next_pc;
	assign retire_rd_we   = rd_we;
	assign retire_rd      = rd;
	assign retire_data    = wb_data;

endmodule

//--- dv/top_asserts.sv
// Fetch protocol checks
module top_asserts (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   imem_req_valid,
	input  logic                   imem_req_ready,
	input  core_pkg::word_t        imem_addr,
	input  logic                   imem_rsp_valid,
	input  logic                   exec_en,
	input  core_pkg::fetch_state_t state
);

	import core_pkg::*;

	// a stalled request keeps valid high and the address steady.
	req_held: assert property (@(posedge clk) disable iff (rst)
		imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_addr))
		else $error("fetch request changed before the transfer");

	exec_single: assert property (@(posedge clk) disable iff (rst) exec_en |=> !exec_en)
		else $error("exec_en stayed high for two cycles");

	// responses only while the fetch unit waits for one.
	rsp_in_wait: assert property (@(posedge clk) disable iff (rst)
		imem_rsp_valid |-> state == FETCH_WAIT)
		else $error("fetch response arrived outside FETCH_WAIT");

endmodule

//--- dv/tb_top.sv
// RV32I core testbench
module tb_top;

	import core_pkg::*;

	localparam word_t RESET_PC        = 32'h0000_0000;
	localparam int    DMEM_WORDS      = 64;
	localparam int    NUM_INSTS       = 300;
	localparam int    CLK_PERIOD      = 20;
	localparam int    MAX_INST_CYCLES = 10;   // 4 request, 4 response, 1 exec, 1 spare.
	localparam int    WATCHDOG_TIME   = (NUM_INSTS * MAX_INST_CYCLES + 50) * CLK_PERIOD;

	logic     clk = 1'b0;
	logic     rst;
	logic     imem_req_valid, imem_req_ready, imem_rsp_valid;
	word_t    imem_addr;
	inst_t    imem_rsp_data;
	logic     retire_valid, retire_rd_we;
	word_t    retire_pc, retire_next_pc, retire_data;
	reg_idx_t retire_rd;

	word_t    lcg_state = 32'h48e8905e;
	word_t    model_regs [32] = '{default: '0};
	word_t    model_mem [DMEM_WORDS] = '{default: '0};
	word_t    model_pc = RESET_PC;
	word_t    exp_fetch_addr = RESET_PC;   // next address the core must fetch.
	inst_t    cur_inst = '0;
	inst_t    pending_lw = '0;
	logic     lw_pending = 1'b0;
	logic     rsp_last = 1'b0;
	int       error_count = 0;
	int       retire_count = 0;
	int       rsp_count = 0;
	int       fetch_count = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	top #(.RESET_PC(RESET_PC), .DMEM_WORDS(DMEM_WORDS)) top_inst (
		.clk(clk), .rst(rst),
		.imem_req_valid(imem_req_valid), .imem_req_ready(imem_req_ready),
		.imem_addr(imem_addr), .imem_rsp_valid(imem_rsp_valid),
		.imem_rsp_data(imem_rsp_data), .retire_valid(retire_valid),
		.retire_pc(retire_pc), .retire_next_pc(retire_next_pc),
		.retire_rd_we(retire_rd_we), .retire_rd(retire_rd), .retire_data(retire_data)
	);

	bind ifu top_asserts u_top_asserts (
		.clk(clk), .rst(rst), .imem_req_valid(imem_req_valid),
		.imem_req_ready(imem_req_ready), .imem_addr(imem_addr),
		.imem_rsp_valid(imem_rsp_valid), .exec_en(exec_en), .state(state)
	);

	function automatic word_t rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int n);
		word_t r;
		r = rand_word();
		return int'(r[31:16]) % n;   // upper bits, the low ones repeat quickly.
	endfunction

	// random program, an sw is always followed by an lw of the same word.
	function automatic inst_t gen_inst();
		inst_t       ins;
		word_t       r;
		logic [4:0]  rd, rs1, rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm12;
		logic [12:0] boff;
		logic [20:0] joff;
		int          kind;
		r     = rand_word();
		rd    = 5'(rand_below(8));
		rs1   = 5'(rand_below(8));
		rs2   = 5'(rand_below(8));
		f3    = 3'(rand_below(8));
		imm12 = r[27:16];
		kind  = rand_below(16);
		if (lw_pending) begin
			ins        = pending_lw;
			lw_pending = 1'b0;
		end else if (kind < 4) begin
			if (f3 == 3'b001) imm12[11:5] = 7'b0000000;
			if (f3 == 3'b101) imm12[11:5] = {1'b0, r[31], 5'b00000};   // srli or srai.
			ins = {imm12, rs1, f3, rd, OPC_OPIMM};
		end else if (kind < 7) begin
			f7  = ((f3 == 3'b000 || f3 == 3'b101) && r[30]) ? 7'b0100000 : 7'b0000000;
			ins = {f7, rs2, rs1, f3, rd, OPC_OP};
		end else if (kind == 7) begin
			ins = {r[31:12], rd, OPC_LUI};
		end else if (kind == 8) begin
			ins = {r[31:12], rd, OPC_AUIPC};
		end else if (kind < 11) begin
			boff = 13'((rand_below(32) - 16) * 4);
			f3   = 3'(rand_below(6));
			if (f3 > 3'd1) f3 = f3 + 3'd2;   // skip the reserved encodings.
			ins = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
		end else if (kind == 11) begin
			joff = 21'((rand_below(64) - 32) * 4);
			ins  = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
		end else if (kind == 12) begin
			ins = {imm12, rs1, 3'b000, rd, OPC_JALR};
		end else if (kind < 15) begin
			imm12[1:0] = 2'b00;
			ins        = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], OPC_STORE};
			pending_lw = {imm12, rs1, 3'b010, rd, OPC_LOAD};
			lw_pending = 1'b1;
		end else begin
			ins = {imm12, rs1, 3'b010, rd, OPC_LOAD};
		end
		return ins;
	endfunction

	// executes one instruction on the model state.
	function automatic void ref_exec(input inst_t ins, output word_t npc, output logic we,
			output reg_idx_t rd, output word_t data);
		word_t      a, b, opb, imm_i, imm_s, imm_b, imm_u, imm_j;
		logic [6:0] opc;
		logic [2:0] f3;
		logic       take;
		opc   = ins[6:0];
		rd    = ins[11:7];
		f3    = ins[14:12];
		a     = model_regs[ins[19:15]];
		b     = model_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'h000};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		npc   = model_pc + 32'd4;
		we    = 1'b0;
		data  = '0;
		take  = 1'b0;
		case (opc)
			OPC_LUI: begin
				we   = 1'b1;
				data = imm_u;
			end
			OPC_AUIPC: begin
				we   = 1'b1;
				data = model_pc + imm_u;
			end
			OPC_JAL: begin
				we   = 1'b1;
				data = model_pc + 32'd4;
				npc  = model_pc + imm_j;
			end
			OPC_JALR: begin
				we   = 1'b1;
				data = model_pc + 32'd4;
				npc  = (a + imm_i) & ~32'd1;
			end
			OPC_BRANCH: begin
				case (f3)
					3'b000:  take = (a == b);
					3'b001:  take = (a != b);
					3'b100:  take = ($signed(a) < $signed(b));
					3'b101:  take = ($signed(a) >= $signed(b));
					3'b110:  take = (a < b);
					default: take = (a >= b);
				endcase
				if (take) npc = model_pc + imm_b;
			end
			OPC_LOAD: begin
				we   = 1'b1;
				data = model_mem[((a + imm_i) >> 2) % DMEM_WORDS];
			end
			OPC_STORE: model_mem[((a + imm_s) >> 2) % DMEM_WORDS] = b;
			OPC_OPIMM, OPC_OP: begin
				we  = 1'b1;
				opb = (opc == OPC_OP) ? b : imm_i;
				case (f3)
					3'b000:  data = (opc == OPC_OP && ins[30]) ? a - opb : a + opb;
					3'b001:  data = a << opb[4:0];
					3'b010:  data = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
					3'b011:  data = (a < opb) ? 32'd1 : 32'd0;
					3'b100:  data = a ^ opb;
					3'b101: begin
						if (ins[30]) begin
							data = $signed(a) >>> opb[4:0];   // sign bit fills in.
						end else begin
							data = a >> opb[4:0];
						end
					end
					3'b110:  data = a | opb;
					default: data = a & opb;
				endcase
			end
			default: ;
		endcase
		we = we && (rd != 5'd0);
		if (we) model_regs[rd] = data;
		model_pc = npc;
	endfunction

	task automatic compare_word(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			error_count++;
			$display("ERROR %s: expected %h, actual %h (inst %h)", name, expected, actual,
				cur_inst);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// one request and its response, with random stalls.
	task automatic serve_fetch();
		int stall, delay;
		stall = rand_below(4);
		delay = 1 + rand_below(4);
		while (!imem_req_valid) begin
			next_cycle();
		end
		repeat (stall) next_cycle();
		if (fetch_count == 0 && retire_count != 0) begin
			error_count++;
			$display("a retire happened before the first fetch");
		end
		compare_word("imem_addr", exp_fetch_addr, imem_addr);
		imem_req_ready = 1'b1;   // transfers on the next edge.
		next_cycle();
		imem_req_ready = 1'b0;
		repeat (delay - 1) next_cycle();
		cur_inst       = gen_inst();
		imem_rsp_valid = 1'b1;
		imem_rsp_data  = cur_inst;
		next_cycle();
		imem_rsp_valid = 1'b0;
		fetch_count++;
	endtask

	task automatic report_and_finish();
		$display("errors=%0d retires=%0d responses=%0d", error_count, retire_count, rsp_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	// trace is sampled mid-cycle.
	always @(negedge clk) begin : retire_check
		word_t    exp_npc, exp_data;
		logic     exp_we;
		reg_idx_t exp_rd;
		if (retire_valid !== rsp_last) begin
			error_count++;
			$display("retire_valid does not follow the response by exactly one cycle");
		end
		rsp_last = imem_rsp_valid;
		if (imem_rsp_valid) rsp_count++;
		if (retire_valid) begin
			retire_count++;
			compare_word("retire_pc", model_pc, retire_pc);
			ref_exec(cur_inst, exp_npc, exp_we, exp_rd, exp_data);
			compare_word("retire_next_pc", exp_npc, retire_next_pc);
			compare_word("retire_rd_we", word_t'(exp_we), word_t'(retire_rd_we));
			if (exp_we) begin
				compare_word("retire_rd", word_t'(exp_rd), word_t'(retire_rd));
				compare_word("retire_data", exp_data, retire_data);
			end
			exp_fetch_addr = exp_npc;
		end
	end

	initial begin
		rst            = 1'b1;
		imem_req_ready = 1'b0;
		imem_rsp_valid = 1'b0;
		imem_rsp_data  = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		while (fetch_count < NUM_INSTS) begin
			serve_fetch();
		end
		repeat (2) next_cycle();   // last instruction retires.
		if (retire_count != rsp_count) begin
			error_count++;
			$display("retire count %0d differs from response count %0d", retire_count,
				rsp_count);
		end
		report_and_finish();
	end

	initial begin : watchdog
		#(WATCHDOG_TIME);
		error_count++;
		$display("timeout: the core stopped fetching or retiring before the program ended");
		report_and_finish();
	end

endmodule

//--- files.f
rtl/core_pkg.sv
rtl/pcu.sv
rtl/ifu.sv
rtl/idu.sv
rtl/gpr.sv
rtl/exu.sv
rtl/lsu.sv
rtl/top.sv
dv/top_asserts.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f files.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
	exit 1
fi
exit 0
